// ==== aud_mixer.f ====
hw/aud_pkg.sv
hw/aud_host_regs.sv
hw/aud_deglitch.sv
hw/aud_sum_stage.sv
hw/aud_crossmix.sv
hw/aud_level.sv
hw/aud_mixer_top.sv
bench/aud_mixer_chk.sv
bench/aud_mixer_tb.sv

// ==== Bender.yml ====
package:
  name: aud_mixer

sources:
  # Mixer RTL, package first
  - hw/aud_pkg.sv
  - hw/aud_host_regs.sv
  - hw/aud_deglitch.sv
  - hw/aud_sum_stage.sv
  - hw/aud_crossmix.sv
  - hw/aud_level.sv
  - hw/aud_mixer_top.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - bench/aud_mixer_chk.sv
      - bench/aud_mixer_tb.sv

// ==== bench/aud_mixer_tb.sv ====
`timescale 1ns/100ps

module aud_mixer_tb import aud_pkg::*; ();

	localparam int CLK_NS      = 100;
	// Longer than the 9-clock core-to-output latency
	localparam int SETTLE_CLKS = 16;
	localparam int N_VEC       = 82;
	// Host writes roughly double the time spent per vector
	localparam int WATCHDOG_NS = (2 * N_VEC + 20) * SETTLE_CLKS * CLK_NS;

	logic        clk;
	logic        resetd;
	logic        io_uio;
	logic        io_strobe;
	logic [15:0] io_din;
	logic [15:0] core_l;
	logic [15:0] core_r;
	logic [15:0] host_l;
	logic [15:0] host_r;
	logic [1:0]  mix;
	logic        sgn;
	wire  [15:0] out_l;
	wire  [15:0] out_r;

	logic [4:0]  model_att = '0;
	int          check_count = 0;
	int          error_count = 0;
	int          test_checks = 0;
	int          test_errors = 0;
	int          test_count = 0;
	string       name_q[$];
	logic [15:0] exp_l_q[$];
	logic [15:0] exp_r_q[$];

	aud_mixer_top #(.SETTLE(2)) dut0 (
		.clk         (clk),
		.resetd      (resetd),
		.i_io_uio    (io_uio),
		.i_io_strobe (io_strobe),
		.i_io_din    (io_din),
		.i_core_l    (core_l),
		.i_core_r    (core_r),
		.i_host_l    (host_l),
		.i_host_r    (host_r),
		.i_mix       (mix),
		.i_signed    (sgn),
		.o_out_l     (out_l),
		.o_out_r     (out_r)
	);

	initial clk = 1'b0;
	always #(CLK_NS / 2) clk = ~clk;

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic logic signed [16:0] ref_sum(input logic [15:0] core,
			input logic [15:0] host, input logic s);
		logic signed [16:0] a;
		if (s) begin
			a = {core[15], core};
		end else begin
			a = {2'b00, core[15:1]};
		end
		return a + {host[15], host};
	endfunction

	function automatic logic [15:0] ref_out(input logic [15:0] c_own, input logic [15:0] h_own,
			input logic [15:0] c_oth, input logic [15:0] h_oth, input logic s,
			input logic [1:0] m, input logic [4:0] att);
		logic signed [16:0] sum;
		logic signed [16:0] q;
		logic signed [16:0] c;
		logic signed [16:0] d;
		logic [15:0]        p;
		sum = ref_sum(c_own, h_own, s);
		// Other channel's halved sum, sign-extended back to 17 bits
		p = 16'(ref_sum(c_oth, h_oth, s) >>> 1);
		q = {p[15], p};
		case (m)
			2'd0: c = sum;
			2'd1: c = sum - (sum >>> 3) + (q >>> 2);
			2'd2: c = sum - (sum >>> 2) + (q >>> 1);
			default: c = (sum >>> 1) + q;
		endcase
		d = att[4] ? 17'sd0 : (c >>> att[3:0]);
		if (d[16] != d[15]) begin
			return d[16] ? 16'h8000 : 16'h7fff;
		end
		return d[15:0];
	endfunction

	function automatic logic [15:0] rand16();
		return 16'($urandom());
	endfunction

	////////////////////////////////////////////////////////////
	// Stimulus and checking helpers
	////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic push_check(input string name, input logic [15:0] el, input logic [15:0] er);
		exp_l_q.push_back(el);
		exp_r_q.push_back(er);
		name_q.push_back(name);
	endtask

	task automatic apply_vector(input string name, input logic [15:0] cl, input logic [15:0] cr,
			input logic [15:0] hl, input logic [15:0] hr, input logic s, input logic [1:0] m);
		@(negedge clk);
		core_l = cl;
		core_r = cr;
		host_l = hl;
		host_r = hr;
		sgn    = s;
		mix    = m;
		repeat (SETTLE_CLKS) @(negedge clk);
		push_check(name, ref_out(cl, hl, cr, hr, s, m, model_att),
			ref_out(cr, hr, cl, hl, s, m, model_att));
	endtask

	task automatic set_select(input logic v);
		@(negedge clk);
		io_uio = v;
	endtask

	// One word per two clocks, strobe high then low
	task automatic host_word(input logic [15:0] word);
		@(negedge clk);
		io_din    = word;
		io_strobe = 1'b1;
		@(negedge clk);
		io_strobe = 1'b0;
	endtask

	task automatic write_att(input logic [4:0] att);
		set_select(1'b1);
		host_word({8'h5a, CMD_VOL_ATT});
		// Upper data bits carry junk
		host_word({11'h5a5, att});
		set_select(1'b0);
		model_att = att;
	endtask

	task automatic end_test(input string name);
		wait (name_q.size() == 0);
		$display("test %s done: %0d checks, %0d errors", name,
			check_count - test_checks, error_count - test_errors);
		test_checks = check_count;
		test_errors = error_count;
		test_count++;
	endtask

	// Compares each queued expectation against the outputs
	initial begin
		forever begin
			wait (name_q.size() != 0);
			check_value({name_q[0], " left"}, exp_l_q[0], out_l);
			check_value({name_q[0], " right"}, exp_r_q[0], out_r);
			void'(exp_l_q.pop_front());
			void'(exp_r_q.pop_front());
			void'(name_q.pop_front());
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		logic [15:0] keep_l;
		logic [15:0] keep_r;
		logic [15:0] big_c [4];
		logic [15:0] big_h [4];
		void'($urandom(32'h17f7_64d1));
		{io_uio, io_strobe, io_din, core_l, core_r, host_l, host_r, mix, sgn} = '0;
		big_c = '{16'h7fff, 16'h8000, 16'h7000, 16'h9000};
		big_h = '{16'h7fff, 16'h8000, 16'h6000, 16'ha000};
		resetd = 1'b1;
		repeat (3) @(negedge clk);
		resetd = 1'b0;
		push_check("reset", 16'h0000, 16'h0000);
		repeat (SETTLE_CLKS) @(negedge clk);
		push_check("reset", 16'h0000, 16'h0000);
		end_test("reset");

		for (int i = 0; i < 20; i++) begin
			apply_vector("unsigned_mix0", rand16(), rand16(), rand16(), rand16(), 1'b0, MIX_NONE);
		end
		end_test("unsigned_mix0");

		for (int m = 1; m < 4; m++) begin
			for (int i = 0; i < 10; i++) begin
				apply_vector("signed_crossmix", rand16(), rand16(), rand16(), rand16(), 1'b1, 2'(m));
			end
		end
		end_test("signed_crossmix");

		for (int sh = 1; sh < 16; sh++) begin
			write_att(5'(sh));
			apply_vector("host_shift", rand16(), rand16(), rand16(), rand16(), 1'b1, 2'(sh));
		end
		write_att(5'h10 | 5'(sh_rand()));
		apply_vector("host_mute", rand16(), rand16(), rand16(), rand16(), 1'b1, MIX_HALF);
		write_att(5'd3);
		apply_vector("host_ignore", rand16(), rand16(), rand16(), rand16(), 1'b1, MIX_NONE);
		// Data for another command must not touch the attenuation
		set_select(1'b1);
		host_word(16'h0027);
		host_word(16'h0010);
		set_select(1'b0);
		apply_vector("host_ignore", rand16(), rand16(), rand16(), rand16(), 1'b1, MIX_NONE);
		// Select drop between volume command and its data
		set_select(1'b1);
		host_word({8'h00, CMD_VOL_ATT});
		set_select(1'b0);
		set_select(1'b1);
		host_word(16'h0013);
		host_word(16'h0011);
		set_select(1'b0);
		apply_vector("host_ignore", rand16(), rand16(), rand16(), rand16(), 1'b1, MIX_LIGHT);
		end_test("host_cmd");

		write_att(5'd0);
		for (int i = 0; i < 4; i++) begin
			apply_vector("clamp", big_c[i], big_c[i], big_h[i], big_h[i], 1'b1, MIX_FULL);
			apply_vector("clamp", big_c[i], big_c[i], big_h[i], big_h[i], 1'b1, MIX_NONE);
		end
		end_test("clamp");

		apply_vector("deglitch", 16'h1234, 16'hedcb, 16'h0100, 16'hff00, 1'b1, MIX_NONE);
		keep_l = ref_out(16'h1234, 16'h0100, 16'hedcb, 16'hff00, 1'b1, MIX_NONE, model_att);
		keep_r = ref_out(16'hedcb, 16'hff00, 16'h1234, 16'h0100, 1'b1, MIX_NONE, model_att);
		for (int k = 0; k < 24; k++) begin
			@(negedge clk);
			core_l = k[0] ? 16'h4000 : 16'hc000;
			core_r = k[0] ? 16'hc000 : 16'h4000;
			push_check("deglitch_toggle", keep_l, keep_r);
		end
		apply_vector("deglitch", 16'h2222, 16'hdddd, 16'h0100, 16'hff00, 1'b1, MIX_NONE);
		end_test("deglitch");

		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Random shift for the mute write
	function automatic logic [3:0] sh_rand();
		return 4'($urandom());
	endfunction

endmodule

// ==== bench/aud_mixer_chk.sv ====
`timescale 1ns/100ps

module aud_mixer_chk import aud_pkg::*; (
	input logic             clk,
	input logic             resetd,
	input logic [ATT_W-1:0] i_att,
	input sample_t          i_out
);

	// Synchronous reset clears the level output on the next clock
	reset_clears: assert property (@(posedge clk) resetd |=> i_out == '0)
		else $error("level output not zero on the clock after reset");

	// Two muted clocks flush both register stages
	mute_silences: assert property (@(posedge clk) disable iff (resetd)
		i_att[ATT_MUTE_BIT] ##1 i_att[ATT_MUTE_BIT] |=> i_out == '0)
		else $error("level output not zero while muted");

endmodule

bind aud_level aud_mixer_chk chk0 (
	.clk    (clk),
	.resetd (resetd),
	.i_att  (i_att),
	.i_out  (o_out)
);

// ==== hw/aud_mixer_top.sv ====
`timescale 1ns/100ps

module aud_mixer_top import aud_pkg::*; #(
	parameter int SETTLE = 2
) (
	input  logic                clk,
	input  logic                resetd,

	// Host command port
	input  logic                i_io_uio,
	input  logic                i_io_strobe,
	input  logic [SAMPLE_W-1:0] i_io_din,

	// Core and host samples
	input  sample_t             i_core_l,
	input  sample_t             i_core_r,
	input  sample_t             i_host_l,
	input  sample_t             i_host_r,
	input  logic [1:0]          i_mix,
	input  logic                i_signed,

	output sample_t             o_out_l,
	output sample_t             o_out_r
);

	logic [ATT_W-1:0] att;

	sample_t core_l_ok;
	sample_t core_r_ok;
	sum_t    sum_l;
	sum_t    sum_r;
	sample_t pre_l;
	sample_t pre_r;
	sum_t    mixed_l;
	sum_t    mixed_r;

	aud_host_regs host_regs0 (
		.clk         (clk),
		.resetd      (resetd),
		.i_io_uio    (i_io_uio),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.o_att       (att)
	);

	////////////////////////////////////////////////////////////
	// Left channel
	////////////////////////////////////////////////////////////

	aud_deglitch #(
		.SETTLE (SETTLE)
	) deglitch_l (
		.clk      (clk),
		.resetd   (resetd),
		.i_sample (i_core_l),
		.o_sample (core_l_ok)
	);

	aud_sum_stage sum_l0 (
		.clk      (clk),
		.resetd   (resetd),
		.i_core   (core_l_ok),
		.i_host   (i_host_l),
		.i_signed (i_signed),
		.o_sum    (sum_l),
		.o_pre    (pre_l)
	);

	// Crossfeed comes from the right channel
	aud_crossmix xmix_l (
		.clk         (clk),
		.resetd      (resetd),
		.i_sum       (sum_l),
		.i_pre_other (pre_r),
		.i_mix       (i_mix),
		.o_mixed     (mixed_l)
	);

	aud_level level_l (
		.clk     (clk),
		.resetd  (resetd),
		.i_mixed (mixed_l),
		.i_att   (att),
		.o_out   (o_out_l)
	);

	////////////////////////////////////////////////////////////
	// Right channel
	////////////////////////////////////////////////////////////

	aud_deglitch #(
		.SETTLE (SETTLE)
	) deglitch_r (
		.clk      (clk),
		.resetd   (resetd),
		.i_sample (i_core_r),
		.o_sample (core_r_ok)
	);

	aud_sum_stage sum_r0 (
		.clk      (clk),
		.resetd   (resetd),
		.i_core   (core_r_ok),
		.i_host   (i_host_r),
		.i_signed (i_signed),
		.o_sum    (sum_r),
		.o_pre    (pre_r)
	);

	aud_crossmix xmix_r (
		.clk         (clk),
		.resetd      (resetd),
		.i_sum       (sum_r),
		.i_pre_other (pre_l),
		.i_mix       (i_mix),
		.o_mixed     (mixed_r)
	);

	aud_level level_r (
		.clk     (clk),
		.resetd  (resetd),
		.i_mixed (mixed_r),
		.i_att   (att),
		.o_out   (o_out_r)
	);

endmodule

// ==== hw/aud_level.sv ====
`timescale 1ns/100ps

module aud_level import aud_pkg::*; (
	input  logic             clk,
	input  logic             resetd,

	input  sum_t             i_mixed,
	input  logic [ATT_W-1:0] i_att,

	output sample_t          o_out
);

	sum_t shifted;
	logic overflow;

	////////////////////////////////////////////////////////////
	// Attenuation
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			shifted <= '0;
		end else if (i_att[ATT_MUTE_BIT]) begin
			shifted <= '0;
		end else begin
			shifted <= i_mixed >>> i_att[ATT_MUTE_BIT-1:0];
		end
	end

	////////////////////////////////////////////////////////////
	// Saturation to 16 bits
	////////////////////////////////////////////////////////////

	// Top two bits disagree when the value is out of range
	assign overflow = shifted[SUM_W-1] ^ shifted[SUM_W-2];

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_out <= '0;
		end else if (overflow) begin
			o_out <= {shifted[SUM_W-1], {(SAMPLE_W-1){shifted[SAMPLE_W-1]}}};
		end else begin
			o_out <= shifted[SAMPLE_W-1:0];
		end
	end

endmodule

// ==== hw/aud_crossmix.sv ====
`timescale 1ns/100ps

module aud_crossmix import aud_pkg::*; (
	input  logic       clk,
	input  logic       resetd,

	input  sum_t       i_sum,
	input  sample_t    i_pre_other,
	input  logic [1:0] i_mix,

	output sum_t       o_mixed
);

	// Other channel widened to the sum width
	sum_t q_ext;
	sum_t blend;

	assign q_ext = i_pre_other;

	////////////////////////////////////////////////////////////
	// Blend selection
	////////////////////////////////////////////////////////////

	always_comb begin
		case (i_mix)
			MIX_NONE: begin
				blend = i_sum;
			end
			MIX_LIGHT: begin
				// Keep 7/8 of own channel, add 1/4 of the other half-scale
				blend = i_sum - (i_sum >>> 3) + (q_ext >>> 2);
			end
			MIX_HALF: begin
				blend = i_sum - (i_sum >>> 2) + (q_ext >>> 1);
			end
			MIX_FULL: begin
				// Equal halves of both channels
				blend = (i_sum >>> 1) + q_ext;
			end
			default: begin
				blend = i_sum;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_mixed <= '0;
		end else begin
			o_mixed <= blend;
		end
	end

endmodule

// ==== hw/aud_sum_stage.sv ====
`timescale 1ns/100ps

module aud_sum_stage import aud_pkg::*; (
	input  logic    clk,
	input  logic    resetd,

	input  sample_t i_core,
	input  sample_t i_host,
	input  logic    i_signed,

	output sum_t    o_sum,
	output sample_t o_pre
);

	sum_t    conv;
	sample_t host_d1;
	sample_t host_d2;

	////////////////////////////////////////////////////////////
	// Format conversion and host sum
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			conv    <= '0;
			host_d1 <= '0;
			host_d2 <= '0;
			o_sum   <= '0;
		end else begin
			// Unsigned samples are halved so they sit beside host audio
			if (i_signed) begin
				conv <= {i_core[SAMPLE_W-1], i_core};
			end else begin
				conv <= {2'b00, i_core[SAMPLE_W-1:1]};
			end

			// Host PCM is delayed two clocks before the add
			host_d1 <= i_host;
			host_d2 <= host_d1;

			o_sum <= conv + $signed({host_d2[SAMPLE_W-1], host_d2});
		end
	end

	// Halved sum for the other channel's crossmix
	always_ff @(posedge clk) begin
		if (resetd) begin
			o_pre <= '0;
		end else begin
			o_pre <= o_sum[SUM_W-1:1];
		end
	end

endmodule

// ==== hw/aud_deglitch.sv ====
`timescale 1ns/100ps

module aud_deglitch import aud_pkg::*; #(
	parameter int SETTLE = 2
) (
	input  logic    clk,
	input  logic    resetd,

	input  sample_t i_sample,
	output sample_t o_sample
);

	// Tap 0 is the first capture, later taps age by one clock each
	sample_t taps [SETTLE+1];
	logic    steady;

	// Last SETTLE taps must all hold the same value
	always_comb begin
		steady = 1'b1;
		for (int i = 2; i <= SETTLE; i++) begin
			if (taps[i] != taps[1]) begin
				steady = 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			for (int i = 0; i <= SETTLE; i++) begin
				taps[i] <= '0;
			end
			o_sample <= '0;
		end else begin
			taps[0] <= i_sample;
			for (int i = 1; i <= SETTLE; i++) begin
				taps[i] <= taps[i-1];
			end
			if (steady) begin
				o_sample <= taps[1];
			end
		end
	end

endmodule

// ==== hw/aud_host_regs.sv ====
`timescale 1ns/100ps

module aud_host_regs import aud_pkg::*; (
	input  logic                clk,
	input  logic                resetd,

	input  logic                i_io_uio,
	input  logic                i_io_strobe,
	input  logic [SAMPLE_W-1:0] i_io_din,

	output logic [ATT_W-1:0]    o_att
);

	logic             old_strobe;
	logic             has_cmd;
	logic [CMD_W-1:0] cmd;
	logic             strobe_rise;

	// Word is taken once per strobe pulse
	assign strobe_rise = i_io_strobe & ~old_strobe;

	always_ff @(posedge clk) begin
		if (resetd) begin
			old_strobe <= 1'b0;
		end else begin
			old_strobe <= i_io_strobe;
		end
	end

	////////////////////////////////////////////////////////////
	// Command / data sequencing
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			has_cmd <= 1'b0;
			cmd     <= '0;
		end else if (!i_io_uio) begin
			// Dropping the select ends the transfer
			has_cmd <= 1'b0;
			cmd     <= '0;
		end else if (strobe_rise && !has_cmd) begin
			has_cmd <= 1'b1;
			cmd     <= i_io_din[CMD_W-1:0];
		end
	end

	// Later words are data for the latched command
	always_ff @(posedge clk) begin
		if (resetd) begin
			o_att <= '0;
		end else if (i_io_uio && strobe_rise && has_cmd) begin
			if (cmd == CMD_VOL_ATT) begin
				o_att <= i_io_din[ATT_W-1:0];
			end
		end
	end

endmodule

// ==== hw/aud_pkg.sv ====
package aud_pkg;

	////////////////////////////////////////////////////////////
	// Sample widths
	////////////////////////////////////////////////////////////

	// Core, host and data word width
	localparam int SAMPLE_W = 16;

	// One guard bit for the core plus host sum
	localparam int SUM_W = SAMPLE_W + 1;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [SUM_W-1:0]    sum_t;

	////////////////////////////////////////////////////////////
	// Stereo mix modes
	////////////////////////////////////////////////////////////

	// Pure stereo
	localparam logic [1:0] MIX_NONE  = 2'd0;
	// About 25 % crossfeed
	localparam logic [1:0] MIX_LIGHT = 2'd1;
	// About 50 % crossfeed
	localparam logic [1:0] MIX_HALF  = 2'd2;
	// Mono
	localparam logic [1:0] MIX_FULL  = 2'd3;

	////////////////////////////////////////////////////////////
	// Host commands and attenuation layout
	////////////////////////////////////////////////////////////

	// Command code lives in the low byte of the first word
	localparam int CMD_W = 8;

	localparam logic [CMD_W-1:0] CMD_VOL_ATT = 8'h26;

	// Bit 4 mutes, bits 3..0 give the right shift
	localparam int ATT_W        = 5;
	localparam int ATT_MUTE_BIT = 4;

endpackage
